/* logic/mipsPkg.sv */
package mipsPkg;

    //////////////////////////////////////////////////////////////////////
    // word and field types
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  regDst_t;

    // alu operations
    localparam aluOp_t ALU_ADD = 4'd0;
    localparam aluOp_t ALU_SUB = 4'd1;
    localparam aluOp_t ALU_AND = 4'd2;
    localparam aluOp_t ALU_OR  = 4'd3;
    localparam aluOp_t ALU_XOR = 4'd4;
    localparam aluOp_t ALU_NOR = 4'd5;
    localparam aluOp_t ALU_SLT = 4'd6;
    localparam aluOp_t ALU_SLL = 4'd7;
    localparam aluOp_t ALU_SRL = 4'd8;
    localparam aluOp_t ALU_SRA = 4'd9;
    localparam aluOp_t ALU_LUI = 4'd10;

    // destination register select
    localparam regDst_t REGDST_RT = 2'd0;
    localparam regDst_t REGDST_RD = 2'd1;
    // link register, r31
    localparam regDst_t REGDST_RA = 2'd2;

    // primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;

    // r-type function codes
    localparam funct_t FN_SLL = 6'h00;
    localparam funct_t FN_SRL = 6'h02;
    localparam funct_t FN_SRA = 6'h03;
    localparam funct_t FN_JR  = 6'h08;
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_XOR = 6'h26;
    localparam funct_t FN_NOR = 6'h27;
    localparam funct_t FN_SLT = 6'h2a;

    //////////////////////////////////////////////////////////////////////
    // control and stage structs
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        regDst_t regDst;
        aluOp_t  aluOp;
        // second operand from immediate
        logic    aluSrc;
        // andi ori xori
        logic    zeroExt;
        // shift amount from shamt field
        logic    shiftImm;
        logic    branch;
        logic    branchNe;
        logic    jump;
        logic    jumpReg;
        // write pc+4 instead of alu result
        logic    link;
        logic    regWrite;
    } ctrl_t;

    // decode to execute
    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        word_t      pcPlus4;
        word_t      jumpTarget;
        word_t      readData1;
        word_t      readData2;
        word_t      imm;
        regAddr_t   rt;
        regAddr_t   rd;
        logic [4:0] shamt;
    } decEx_t;

    // execute to result
    typedef struct packed {
        logic     valid;
        logic     regWrite;
        regDst_t  regDst;
        logic     link;
        regAddr_t rt;
        regAddr_t rd;
        word_t    aluResult;
        word_t    pcPlus4;
    } exRes_t;

endpackage

/* logic/instrController.sv */
`timescale 1ns/100ps

module instrController import mipsPkg::*; (
    input  opcode_t  opcode,
    input  funct_t   funct,
    input  regAddr_t rt,
    output ctrl_t    ctrl
);

    //////////////////////////////////////////////////////////////////////
    // combinational decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // anything not matched below stays a nop
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regDst   = REGDST_RD;
                ctrl.regWrite = 1'b1;
                case (funct)
                    FN_ADD: ctrl.aluOp = ALU_ADD;
                    FN_SUB: ctrl.aluOp = ALU_SUB;
                    FN_AND: ctrl.aluOp = ALU_AND;
                    FN_OR:  ctrl.aluOp = ALU_OR;
                    FN_XOR: ctrl.aluOp = ALU_XOR;
                    FN_NOR: ctrl.aluOp = ALU_NOR;
                    FN_SLT: ctrl.aluOp = ALU_SLT;
                    // constant shifts, amount from shamt
                    FN_SLL: begin
                        ctrl.aluOp    = ALU_SLL;
                        ctrl.shiftImm = 1'b1;
                    end
                    FN_SRL: begin
                        ctrl.aluOp    = ALU_SRL;
                        ctrl.shiftImm = 1'b1;
                    end
                    FN_SRA: begin
                        ctrl.aluOp    = ALU_SRA;
                        ctrl.shiftImm = 1'b1;
                    end
                    // jr has no rt operand, a set rt field is a bad encoding
                    FN_JR: begin
                        ctrl         = '0;
                        ctrl.jumpReg = (rt == '0);
                    end
                    default: ctrl = '0;
                endcase
            end
            // immediate alu ops write rt
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.regDst   = REGDST_RT;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (opcode)
                    OP_ADDI: ctrl.aluOp = ALU_ADD;
                    OP_SLTI: ctrl.aluOp = ALU_SLT;
                    OP_ANDI: ctrl.aluOp = ALU_AND;
                    OP_ORI:  ctrl.aluOp = ALU_OR;
                    OP_XORI: ctrl.aluOp = ALU_XOR;
                    default: ctrl.aluOp = ALU_LUI;
                endcase
                // logical immediates are unsigned
                ctrl.zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                               (opcode == OP_XORI);
            end
            // branches compare rs and rt
            OP_BEQ: ctrl.branch = 1'b1;
            OP_BNE: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
            end
            OP_J: ctrl.jump = 1'b1;
            // jal links into r31
            OP_JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regDst   = REGDST_RA;
                ctrl.regWrite = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/100ps

module registerFile import mipsPkg::*; (
    input  logic     Clk,
    input  logic     reset,
    input  regAddr_t readReg1,
    input  regAddr_t readReg2,
    input  logic     writeEnable,
    input  regAddr_t writeReg,
    input  word_t    writeData,
    output word_t    readData1,
    output word_t    readData2
);

    word_t regs [32];

    // r0 never takes a write
    logic  writeLive;

    assign writeLive = writeEnable && (writeReg != '0);

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[writeReg] <= writeData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////////////////////////

    // same-cycle write shows through, covers issue distance of two
    assign readData1 = (writeLive && (writeReg == readReg1)) ? writeData : regs[readReg1];
    assign readData2 = (writeLive && (writeReg == readReg2)) ? writeData : regs[readReg2];

endmodule

/* logic/instructionDecodePhase.sv */
`timescale 1ns/100ps

module instructionDecodePhase import mipsPkg::*; (
    input  logic     Clk,
    input  logic     reset,
    input  logic     instrValid,
    input  word_t    instr,
    input  word_t    pcPlus4,
    // write port, driven from result phase
    input  logic     wbEnable,
    input  regAddr_t wbReg,
    input  word_t    wbData,
    output decEx_t   decEx
);

    ctrl_t    ctrl;
    word_t    readData1;
    word_t    readData2;
    word_t    imm;
    word_t    jumpTarget;

    // instruction fields
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;

    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    //////////////////////////////////////////////////////////////////////
    // controller and register file
    //////////////////////////////////////////////////////////////////////

    instrController controller0 (
        .opcode (instr[31:26]),
        .funct  (instr[5:0]),
        .rt     (rt),
        .ctrl   (ctrl)
    );

    registerFile regFile0 (
        .Clk         (Clk),
        .reset       (reset),
        .readReg1    (rs),
        .readReg2    (rt),
        .writeEnable (wbEnable),
        .writeReg    (wbReg),
        .writeData   (wbData),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    // immediate, zero or sign extended
    assign imm = ctrl.zeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    // pseudo-direct target, region bits from pc+4
    assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

    //////////////////////////////////////////////////////////////////////
    // decode/execute register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            decEx.valid <= 1'b0;
        end else begin
            decEx.valid <= instrValid;
        end
        // payload follows every cycle, valid qualifies it
        decEx.ctrl       <= ctrl;
        decEx.pcPlus4    <= pcPlus4;
        decEx.jumpTarget <= jumpTarget;
        decEx.readData1  <= readData1;
        decEx.readData2  <= readData2;
        decEx.imm        <= imm;
        decEx.rt         <= rt;
        decEx.rd         <= rd;
        decEx.shamt      <= instr[10:6];
    end

endmodule

/* logic/executePhase.sv */
`timescale 1ns/100ps

module executePhase import mipsPkg::*; (
    input  logic   Clk,
    input  logic   reset,
    input  decEx_t decEx,
    output logic   redirectValid,
    output word_t  redirectTarget,
    output exRes_t exRes
);

    word_t      operandA;
    word_t      operandB;
    logic [4:0] shiftAmt;
    word_t      aluResult;
    word_t      branchTarget;
    logic       regsEqual;
    logic       branchTaken;

    //////////////////////////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////////////////////////

    assign operandA = decEx.readData1;
    assign operandB = decEx.ctrl.aluSrc ? decEx.imm : decEx.readData2;

    // shamt field or low bits of rs
    assign shiftAmt = decEx.ctrl.shiftImm ? decEx.shamt : decEx.readData1[4:0];

    always_comb begin
        case (decEx.ctrl.aluOp)
            ALU_ADD: aluResult = operandA + operandB;
            ALU_SUB: aluResult = operandA - operandB;
            ALU_AND: aluResult = operandA & operandB;
            ALU_OR:  aluResult = operandA | operandB;
            ALU_XOR: aluResult = operandA ^ operandB;
            ALU_NOR: aluResult = ~(operandA | operandB);
            // signed compare
            ALU_SLT: aluResult = {31'b0, $signed(operandA) < $signed(operandB)};
            // shifts act on rt
            ALU_SLL: aluResult = decEx.readData2 << shiftAmt;
            ALU_SRL: aluResult = decEx.readData2 >> shiftAmt;
            ALU_SRA: aluResult = word_t'($signed(decEx.readData2) >>> shiftAmt);
            ALU_LUI: aluResult = {decEx.imm[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // branch and jump resolution
    //////////////////////////////////////////////////////////////////////

    assign regsEqual    = (decEx.readData1 == decEx.readData2);
    // beq on equal, bne on not equal
    assign branchTaken  = decEx.ctrl.branch && (regsEqual != decEx.ctrl.branchNe);
    assign branchTarget = decEx.pcPlus4 + {decEx.imm[29:0], 2'b00};

    assign redirectValid = decEx.valid &&
                           (decEx.ctrl.jump || decEx.ctrl.jumpReg || branchTaken);

    always_comb begin
        if (decEx.ctrl.jumpReg) begin
            // jr goes to rs
            redirectTarget = decEx.readData1;
        end else if (decEx.ctrl.jump) begin
            redirectTarget = decEx.jumpTarget;
        end else begin
            redirectTarget = branchTarget;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // execute/result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            exRes.valid <= 1'b0;
        end else begin
            exRes.valid <= decEx.valid;
        end
        exRes.regWrite  <= decEx.ctrl.regWrite;
        exRes.regDst    <= decEx.ctrl.regDst;
        exRes.link      <= decEx.ctrl.link;
        exRes.rt        <= decEx.rt;
        exRes.rd        <= decEx.rd;
        exRes.aluResult <= aluResult;
        exRes.pcPlus4   <= decEx.pcPlus4;
    end

endmodule

/* logic/resultPhase.sv */
`timescale 1ns/100ps

module resultPhase import mipsPkg::*; (
    input  exRes_t   exRes,
    output logic     wbEnable,
    output regAddr_t wbReg,
    output word_t    wbData,
    output logic     resultValid,
    output regAddr_t resultReg,
    output word_t    resultData
);

    regAddr_t destReg;
    word_t    destData;

    //////////////////////////////////////////////////////////////////////
    // destination and data select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (exRes.regDst)
            REGDST_RD: destReg = exRes.rd;
            // jal link register
            REGDST_RA: destReg = 5'd31;
            default:   destReg = exRes.rt;
        endcase
    end

    // link writes return address
    assign destData = exRes.link ? exRes.pcPlus4 : exRes.aluResult;

    // r0 writes dropped here, so no retire pulse either
    assign wbEnable = exRes.valid && exRes.regWrite && (destReg != '0);
    assign wbReg    = destReg;
    assign wbData   = destData;

    // retire view is the write port
    assign resultValid = wbEnable;
    assign resultReg   = destReg;
    assign resultData  = destData;

endmodule

/* logic/mipsCore.sv */
`timescale 1ns/100ps

module mipsCore import mipsPkg::*; (
    input  logic     Clk,
    input  logic     reset,
    // issue side
    input  logic     instrValid,
    input  word_t    instr,
    input  word_t    pcPlus4,
    // control transfer, one cycle after strobe
    output logic     redirectValid,
    output word_t    redirectTarget,
    // retired writes, two cycles after strobe
    output logic     resultValid,
    output regAddr_t resultReg,
    output word_t    resultData
);

    decEx_t   decEx;
    exRes_t   exRes;

    // write-back path into the decode register file
    logic     wbEnable;
    regAddr_t wbReg;
    word_t    wbData;

    //////////////////////////////////////////////////////////////////////
    // phases
    //////////////////////////////////////////////////////////////////////

    instructionDecodePhase decode0 (
        .Clk        (Clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .pcPlus4    (pcPlus4),
        .wbEnable   (wbEnable),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .decEx      (decEx)
    );

    executePhase execute0 (
        .Clk            (Clk),
        .reset          (reset),
        .decEx          (decEx),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget),
        .exRes          (exRes)
    );

    resultPhase result0 (
        .exRes       (exRes),
        .wbEnable    (wbEnable),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .resultValid (resultValid),
        .resultReg   (resultReg),
        .resultData  (resultData)
    );

endmodule

/* test/mipsCore_asserts.sv */
`timescale 1ns/100ps

module mipsCore_asserts import mipsPkg::*; (
    input logic     Clk,
    input logic     reset,
    input logic     instrValid,
    input logic     redirectValid,
    input logic     resultValid,
    input regAddr_t resultReg
);

    // failures so far
    int failCount = 0;

    //////////////////////////////////////////////////////////////////////
    // reset and latency
    //////////////////////////////////////////////////////////////////////

    // both stage valids clear on a reset edge
    resetQuiet: assert property (@(posedge Clk) reset |=> !redirectValid && !resultValid)
        else begin
            failCount++;
            $error("redirect or result pulse in the cycle after a reset edge");
        end

    // redirect only one cycle after a strobe
    redirectLatency: assert property (@(posedge Clk) disable iff (reset)
        redirectValid |-> $past(instrValid))
        else begin
            failCount++;
            $error("redirectValid without a strobe one cycle earlier");
        end

    // retire only two cycles after a strobe
    resultLatency: assert property (@(posedge Clk) disable iff (reset)
        resultValid |-> $past(instrValid, 2))
        else begin
            failCount++;
            $error("resultValid without a strobe two cycles earlier");
        end

    // r0 never retires
    noZeroRetire: assert property (@(posedge Clk) disable iff (reset)
        resultValid |-> (resultReg != '0))
        else begin
            failCount++;
            $error("retire pulse for register 0");
        end

    // strobes out of reset are always known
    knownStrobes: assert property (@(posedge Clk) disable iff (reset)
        !$isunknown({redirectValid, resultValid}))
        else begin
            failCount++;
            $error("redirectValid or resultValid unknown");
        end

endmodule

bind mipsCore mipsCore_asserts asserts0 (
    .Clk           (Clk),
    .reset         (reset),
    .instrValid    (instrValid),
    .redirectValid (redirectValid),
    .resultValid   (resultValid),
    .resultReg     (resultReg)
);

/* test/mipsCoreTb.sv */
`timescale 1ns/100ps

module mipsCoreTb import mipsPkg::*; ();

    localparam int PROLOGUE_LEN    = 24;
    localparam int RANDOM_LEN      = 300;
    // two cycles per strobe plus reset and drain
    localparam int WATCHDOG_CYCLES = (PROLOGUE_LEN + RANDOM_LEN) * 2 + 20;

    // one expected pulse, stamped with its cycle
    typedef struct packed {
        logic [31:0] cycle;
        regAddr_t    dest;
        word_t       data;
    } expEvent_t;

    logic        Clk;
    logic        reset;
    logic        instrValid;
    word_t       instr;
    word_t       pcPlus4;
    logic        redirectValid;
    word_t       redirectTarget;
    logic        resultValid;
    regAddr_t    resultReg;
    word_t       resultData;

    // reference state
    word_t       refRegs [32];
    expEvent_t   redirQ [$];
    expEvent_t   resultQ [$];
    expEvent_t   expRedir;
    expEvent_t   expResult;
    logic [31:0] cycle;
    integer      seed;
    int          errorCount;
    int          issued;
    word_t       nextInstr;
    word_t       nextPc;

    funct_t  rFuncs [11] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT,
                             FN_SLL, FN_SRL, FN_SRA, FN_JR};
    opcode_t iOps [8]    = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                             OP_BEQ, OP_BNE};

    mipsCore dut0 (
        .Clk            (Clk),
        .reset          (reset),
        .instrValid     (instrValid),
        .instr          (instr),
        .pcPlus4        (pcPlus4),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget),
        .resultValid    (resultValid),
        .resultReg      (resultReg),
        .resultData     (resultData)
    );

    always #50 Clk = ~Clk;

    always @(posedge Clk) cycle <= cycle + 1;

    //////////////////////////////////////////////////////////////////////
    // encoders and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic word_t rTypeWord(funct_t fn, regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                        logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t immWord(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jumpWord(opcode_t op, logic [25:0] index);
        return {op, index};
    endfunction

    // isa semantics, queues the pulses one strobe should cause
    task automatic predict(input word_t ins, input word_t pc4, input logic [31:0] strobe);
        regAddr_t   rs;
        regAddr_t   rt;
        logic [4:0] sh;
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      zext;
        word_t      value;
        word_t      target;
        regAddr_t   dest;
        logic       writes;
        logic       redirect;
        rs       = ins[25:21];
        rt       = ins[20:16];
        sh       = ins[10:6];
        a        = refRegs[rs];
        b        = refRegs[rt];
        sext     = {{16{ins[15]}}, ins[15:0]};
        zext     = {16'h0000, ins[15:0]};
        value    = '0;
        target   = '0;
        dest     = ins[15:11];
        writes   = 1'b0;
        redirect = 1'b0;
        case (ins[31:26])
            OP_RTYPE: begin
                writes = 1'b1;
                case (ins[5:0])
                    FN_ADD: value = a + b;
                    FN_SUB: value = a - b;
                    FN_AND: value = a & b;
                    FN_OR:  value = a | b;
                    FN_XOR: value = a ^ b;
                    FN_NOR: value = ~(a | b);
                    FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL: value = b << sh;
                    FN_SRL: value = b >> sh;
                    FN_SRA: value = $signed(b) >>> sh;
                    // jr takes rs, only with a clear rt field
                    FN_JR: begin
                        writes   = 1'b0;
                        redirect = (rt == '0);
                        target   = a;
                    end
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDI: {writes, dest, value} = {1'b1, rt, a + sext};
            OP_SLTI: {writes, dest, value} = {1'b1, rt, ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0};
            OP_ANDI: {writes, dest, value} = {1'b1, rt, a & zext};
            OP_ORI:  {writes, dest, value} = {1'b1, rt, a | zext};
            OP_XORI: {writes, dest, value} = {1'b1, rt, a ^ zext};
            OP_LUI:  {writes, dest, value} = {1'b1, rt, ins[15:0], 16'h0000};
            // word offset relative to pc+4
            OP_BEQ:  {redirect, target} = {a == b, pc4 + (sext << 2)};
            OP_BNE:  {redirect, target} = {a != b, pc4 + (sext << 2)};
            OP_J:    {redirect, target} = {1'b1, pc4[31:28], ins[25:0], 2'b00};
            OP_JAL: begin
                {redirect, target}     = {1'b1, pc4[31:28], ins[25:0], 2'b00};
                {writes, dest, value}  = {1'b1, 5'd31, pc4};
            end
            default: writes = 1'b0;
        endcase
        if (redirect) begin
            redirQ.push_back(expEvent_t'{strobe + 1, 5'd0, target});
        end
        // r0 stays zero and never retires
        if (writes && (dest != '0)) begin
            resultQ.push_back(expEvent_t'{strobe + 2, dest, value});
            refRegs[dest] = value;
        end
    endtask

    // one strobe, then an idle cycle, which keeps every issue distance at two
    task automatic issueInstr(input word_t ins, input word_t pc4);
        @(posedge Clk);
        instrValid <= 1'b1;
        instr      <= ins;
        pcPlus4    <= pc4;
        predict(ins, pc4, cycle + 1);
        issued++;
        @(posedge Clk);
        instrValid <= 1'b0;
        // noise on the idle cycle, must be ignored
        instr      <= $random(seed);
    endtask

    function automatic word_t randomInstr();
        word_t raw;
        int    pick;
        raw  = $random(seed);
        pick = {$random(seed)} % 21;
        if (pick < 11) begin
            raw = {OP_RTYPE, raw[25:6], rFuncs[pick]};
            if (rFuncs[pick] == FN_JR) begin
                raw[20:16] = '0;
            end
        end else if (pick < 19) begin
            raw = {iOps[pick - 11], raw[25:0]};
        end else begin
            raw = {(pick == 19) ? OP_J : OP_JAL, raw[25:0]};
        end
        return raw;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // output checks, sampled mid cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge Clk) begin
        if (!reset) begin
            if ((redirQ.size() > 0) && (redirQ[0].cycle == cycle)) begin
                expRedir = redirQ.pop_front();
                assert (redirectValid === 1'b1) else begin
                    errorCount++;
                    $display("ERROR at %0t: redirectValid expected 1, got %b",
                             $time, redirectValid);
                end
                assert (redirectTarget === expRedir.data) else begin
                    errorCount++;
                    $display("ERROR at %0t: redirectTarget expected %h, got %h",
                             $time, expRedir.data, redirectTarget);
                end
            end else begin
                assert (redirectValid === 1'b0) else begin
                    errorCount++;
                    $display("ERROR at %0t: redirectValid expected 0, got %b",
                             $time, redirectValid);
                end
            end
            if ((resultQ.size() > 0) && (resultQ[0].cycle == cycle)) begin
                expResult = resultQ.pop_front();
                assert (resultValid === 1'b1) else begin
                    errorCount++;
                    $display("ERROR at %0t: resultValid expected 1, got %b", $time, resultValid);
                end
                assert (resultReg === expResult.dest) else begin
                    errorCount++;
                    $display("ERROR at %0t: resultReg expected %0d, got %0d",
                             $time, expResult.dest, resultReg);
                end
                assert (resultData === expResult.data) else begin
                    errorCount++;
                    $display("ERROR at %0t: resultData expected %h, got %h",
                             $time, expResult.data, resultData);
                end
            end else begin
                assert (resultValid === 1'b0) else begin
                    errorCount++;
                    $display("ERROR at %0t: resultValid expected 0, got %b", $time, resultValid);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        Clk        = 1'b0;
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pcPlus4    = '0;
        cycle      = '0;
        seed       = 32'h68c0078e;
        errorCount = 0;
        issued     = 0;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        repeat (5) @(posedge Clk);
        reset <= 1'b0;

        // reads straight after reset see zeros
        issueInstr(rTypeWord(FN_ADD, 5'd2, 5'd4, 5'd3, 5'd0), 32'h0000_0004);
        issueInstr(immWord(OP_ADDI, 5'd0, 5'd1, 16'd5), 32'h0000_0008);
        issueInstr(immWord(OP_LUI, 5'd0, 5'd5, 16'h8000), 32'h0000_000c);
        issueInstr(immWord(OP_ORI, 5'd5, 5'd5, 16'h1234), 32'h0000_0010);
        // write to r0 is dropped, then r0 read back
        issueInstr(immWord(OP_ADDI, 5'd1, 5'd0, 16'd7), 32'h0000_0014);
        issueInstr(rTypeWord(FN_ADD, 5'd0, 5'd1, 5'd6, 5'd0), 32'h0000_0018);
        // shifts of a negative word
        issueInstr(rTypeWord(FN_SRA, 5'd0, 5'd5, 5'd7, 5'd4), 32'h0000_001c);
        issueInstr(rTypeWord(FN_SRL, 5'd0, 5'd5, 5'd8, 5'd4), 32'h0000_0020);
        issueInstr(rTypeWord(FN_SLL, 5'd0, 5'd1, 5'd9, 5'd3), 32'h0000_0024);
        issueInstr(rTypeWord(FN_SLT, 5'd5, 5'd1, 5'd10, 5'd0), 32'h0000_0028);
        issueInstr(immWord(OP_SLTI, 5'd1, 5'd11, 16'hffff), 32'h0000_002c);
        issueInstr(immWord(OP_XORI, 5'd5, 5'd12, 16'hffff), 32'h0000_0030);
        issueInstr(rTypeWord(FN_NOR, 5'd1, 5'd0, 5'd13, 5'd0), 32'h0000_0034);
        issueInstr(rTypeWord(FN_SUB, 5'd0, 5'd1, 5'd14, 5'd0), 32'h0000_0038);
        issueInstr(immWord(OP_ANDI, 5'd14, 5'd15, 16'h00f0), 32'h0000_003c);
        // branches, taken and not taken
        issueInstr(immWord(OP_BEQ, 5'd1, 5'd1, 16'd3), 32'h0000_1000);
        issueInstr(immWord(OP_BEQ, 5'd1, 5'd0, 16'd3), 32'h0000_1010);
        issueInstr(immWord(OP_BNE, 5'd1, 5'd0, 16'hfffe), 32'h0000_1020);
        issueInstr(immWord(OP_BNE, 5'd6, 5'd1, 16'd5), 32'h0000_1030);
        // jumps, then a link read at distance two
        issueInstr(jumpWord(OP_J, 26'h0123456), 32'ha000_0000);
        issueInstr(rTypeWord(FN_JR, 5'd5, 5'd0, 5'd0, 5'd0), 32'h0000_1040);
        issueInstr(jumpWord(OP_JAL, 26'h0000040), 32'h0000_2000);
        issueInstr(rTypeWord(FN_ADD, 5'd31, 5'd1, 5'd16, 5'd0), 32'h0000_2008);
        issueInstr(rTypeWord(FN_OR, 5'd16, 5'd0, 5'd17, 5'd0), 32'h0000_200c);

        repeat (RANDOM_LEN) begin
            nextInstr = randomInstr();
            nextPc    = $random(seed);
            issueInstr(nextInstr, {nextPc[31:2], 2'b00});
        end

        // let the last instruction retire
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        assert ((redirQ.size() == 0) && (resultQ.size() == 0)) else begin
            errorCount++;
            $display("expected pulses never checked: %0d redirects, %0d results left",
                     redirQ.size(), resultQ.size());
        end
        $display("%0d instructions, %0d value errors, %0d assertion failures",
                 issued, errorCount, dut0.asserts0.failCount);
        if ((errorCount == 0) && (dut0.asserts0.failCount == 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge Clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* vlog.f */
logic/mipsPkg.sv
logic/instrController.sv
logic/registerFile.sv
logic/instructionDecodePhase.sv
logic/executePhase.sv
logic/resultPhase.sv
logic/mipsCore.sv
test/mipsCore_asserts.sv
test/mipsCoreTb.sv
